//--- source/sniff_pkg.sv
package sniff_pkg;

  // tag carried on stream_tdest for every captured item
  // the values follow the search order of the arbiter
  typedef enum logic [1:0] {
    CH_AW = 2'd0,
    CH_W  = 2'd1,
    CH_B  = 2'd2
  } channel_e;

  // number of AXI write channels that are tapped
  localparam int NUM_CHANNELS = 3;

  // fixed AXI field widths
  // these do not scale with the bus and stay out of the module parameters
  localparam int SIZE_WIDTH  = 3;
  localparam int BURST_WIDTH = 2;
  localparam int RESP_WIDTH  = 2;

endpackage

//--- source/capture_if.sv
`timescale 1ns/1ps

// one captured AXI handshake waiting for its turn on the stream
// valid is a level held by the tap, grant is a single cycle pulse from the arbiter
interface capture_if #(
  parameter int DATA_WIDTH = 64
);

  logic                  valid;
  logic                  grant;
  logic [DATA_WIDTH-1:0] data;
  logic                  last;

  modport tap (
    output valid,
    output data,
    output last,
    input  grant
  );

  modport arbiter (
    input  valid,
    input  data,
    input  last,
    output grant
  );

endinterface

//--- source/channel_tap.sv
`timescale 1ns/1ps

// passes one AXI channel straight through and keeps a copy of the last handshake
// the channel is held off while its copy has not yet left on the stream
module channel_tap #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  enable,
  input  logic                  up_valid,
  output logic                  up_ready,
  output logic                  down_valid,
  input  logic                  down_ready,
  input  logic [DATA_WIDTH-1:0] payload,
  input  logic                  payload_last,
  capture_if.tap                cap
);

  logic                  slot_full;
  logic [DATA_WIDTH-1:0] slot_data;
  logic                  slot_last;
  logic                  open;
  logic                  handshake;
  logic                  capture;

  // a granted slot empties on this edge, so it can take the next item right away
  assign open = !enable || !slot_full || cap.grant;

  // closing the tap drops both valid and ready so no handshake can slip through
  assign down_valid = open && up_valid;
  assign up_ready   = open && down_ready;

  assign handshake = open && up_valid && down_ready;
  assign capture   = handshake && enable;

  always_ff @(posedge clk) begin
    if (resetn) begin
      slot_full <= 1'b0;
    end else if (capture) begin
      slot_full <= 1'b1;
    end else if (cap.grant) begin
      slot_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      slot_data <= payload;
      slot_last <= payload_last;
    end
  end

  assign cap.valid = slot_full;
  assign cap.data  = slot_data;
  assign cap.last  = slot_last;

  // the arbiter must never pick an empty slot
  a_grant_needs_valid: assert property (
    @(posedge clk) disable iff (resetn)
    cap.grant |-> slot_full
  );

endmodule

//--- source/stream_arbiter.sv
`timescale 1ns/1ps

// round robin over the AW, W and B capture slots onto one AXI-Stream port
// a W burst keeps the stream to itself until its last beat has gone out
module stream_arbiter #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                    clk,
  input  logic                    resetn,
  capture_if.arbiter              aw_cap,
  capture_if.arbiter              w_cap,
  capture_if.arbiter              b_cap,
  output logic [DATA_WIDTH-1:0]   stream_tdata,
  output sniff_pkg::channel_e     stream_tdest,
  output logic                    stream_tlast,
  output logic                    stream_tvalid,
  input  logic                    stream_tready
);

  logic [sniff_pkg::NUM_CHANNELS-1:0] slot_valid;
  logic [sniff_pkg::NUM_CHANNELS-1:0] slot_last;
  logic [DATA_WIDTH-1:0]              slot_data [sniff_pkg::NUM_CHANNELS];
  logic [sniff_pkg::NUM_CHANNELS-1:0] eligible;

  sniff_pkg::channel_e last_ptr;
  sniff_pkg::channel_e rr_pick;
  sniff_pkg::channel_e held_ch;
  sniff_pkg::channel_e pick;
  logic                rr_found;
  logic                hold;
  logic                w_lock;
  logic                transfer;

  assign slot_valid[sniff_pkg::CH_AW] = aw_cap.valid;
  assign slot_valid[sniff_pkg::CH_W]  = w_cap.valid;
  assign slot_valid[sniff_pkg::CH_B]  = b_cap.valid;

  assign slot_last[sniff_pkg::CH_AW] = aw_cap.last;
  assign slot_last[sniff_pkg::CH_W]  = w_cap.last;
  assign slot_last[sniff_pkg::CH_B]  = b_cap.last;

  assign slot_data[sniff_pkg::CH_AW] = aw_cap.data;
  assign slot_data[sniff_pkg::CH_W]  = w_cap.data;
  assign slot_data[sniff_pkg::CH_B]  = b_cap.data;

  // inside a W burst only the W slot may compete
  always_comb begin
    eligible = slot_valid;
    if (w_lock) begin
      eligible = '0;
      eligible[sniff_pkg::CH_W] = slot_valid[sniff_pkg::CH_W];
    end
  end

  // search starts one past the channel that was served last
  always_comb begin
    int idx;
    rr_found = 1'b0;
    rr_pick  = sniff_pkg::CH_AW;
    for (int i = 1; i <= sniff_pkg::NUM_CHANNELS; i++) begin
      idx = (int'(last_ptr) + i) % sniff_pkg::NUM_CHANNELS;
      if (!rr_found && eligible[idx]) begin
        rr_found = 1'b1;
        rr_pick  = sniff_pkg::channel_e'(idx);
      end
    end
  end

  // once offered, an item stays on the stream until it is taken
  // otherwise a slot filling late could cut in front of a stalled one
  assign pick          = hold ? held_ch : rr_pick;
  assign stream_tvalid = hold || rr_found;
  assign stream_tdata  = slot_data[pick];
  assign stream_tlast  = slot_last[pick];
  assign stream_tdest  = pick;

  assign transfer = stream_tvalid && stream_tready;

  assign aw_cap.grant = transfer && (pick == sniff_pkg::CH_AW);
  assign w_cap.grant  = transfer && (pick == sniff_pkg::CH_W);
  assign b_cap.grant  = transfer && (pick == sniff_pkg::CH_B);

  always_ff @(posedge clk) begin
    if (resetn) begin
      // pointing at B makes the first search begin at AW
      last_ptr <= sniff_pkg::CH_B;
      w_lock   <= 1'b0;
      hold     <= 1'b0;
    end else begin
      hold <= stream_tvalid && !stream_tready;
      if (transfer) begin
        last_ptr <= pick;
        if (pick == sniff_pkg::CH_W) begin
          w_lock <= !slot_last[sniff_pkg::CH_W];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    held_ch <= pick;
  end

  // a W burst is never split by an address or a response item
  a_lock_keeps_w: assert property (
    @(posedge clk) disable iff (resetn)
    w_lock |-> !(aw_cap.grant || b_cap.grant)
  );

  a_stream_stable: assert property (
    @(posedge clk) disable iff (resetn)
    (stream_tvalid && !stream_tready) |=>
      (stream_tvalid && $stable(stream_tdata) && $stable(stream_tdest) &&
       $stable(stream_tlast))
  );

endmodule

//--- source/axi_write_sniffer.sv
`timescale 1ns/1ps

// AXI write path pass-through that copies every AW, W and B handshake
// onto an AXI-Stream port tagged with its channel
module axi_write_sniffer #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 32,
  parameter int LEN_WIDTH  = 8
) (
  input  logic                                 clk,
  input  logic                                 resetn,
  input  logic [sniff_pkg::NUM_CHANNELS-1:0]   channel_enable,

  input  logic [ADDR_WIDTH-1:0]                s_awaddr,
  input  logic [LEN_WIDTH-1:0]                 s_awlen,
  input  logic [sniff_pkg::SIZE_WIDTH-1:0]     s_awsize,
  input  logic [sniff_pkg::BURST_WIDTH-1:0]    s_awburst,
  input  logic                                 s_awvalid,
  output logic                                 s_awready,
  input  logic [DATA_WIDTH-1:0]                s_wdata,
  input  logic                                 s_wlast,
  input  logic                                 s_wvalid,
  output logic                                 s_wready,
  output logic [sniff_pkg::RESP_WIDTH-1:0]     s_bresp,
  output logic                                 s_bvalid,
  input  logic                                 s_bready,

  output logic [ADDR_WIDTH-1:0]                m_awaddr,
  output logic [LEN_WIDTH-1:0]                 m_awlen,
  output logic [sniff_pkg::SIZE_WIDTH-1:0]     m_awsize,
  output logic [sniff_pkg::BURST_WIDTH-1:0]    m_awburst,
  output logic                                 m_awvalid,
  input  logic                                 m_awready,
  output logic [DATA_WIDTH-1:0]                m_wdata,
  output logic                                 m_wlast,
  output logic                                 m_wvalid,
  input  logic                                 m_wready,
  input  logic [sniff_pkg::RESP_WIDTH-1:0]     m_bresp,
  input  logic                                 m_bvalid,
  output logic                                 m_bready,

  output logic [DATA_WIDTH-1:0]                stream_tdata,
  output sniff_pkg::channel_e                  stream_tdest,
  output logic                                 stream_tlast,
  output logic                                 stream_tvalid,
  input  logic                                 stream_tready
);

  localparam int AW_BITS = ADDR_WIDTH + LEN_WIDTH + sniff_pkg::SIZE_WIDTH +
                           sniff_pkg::BURST_WIDTH;

  // the packed AW fields have to fit in one stream word
  if (DATA_WIDTH < AW_BITS) begin : g_width_check
    $error("DATA_WIDTH %0d cannot hold the %0d packed AW bits", DATA_WIDTH, AW_BITS);
  end

  logic [DATA_WIDTH-1:0] aw_payload;
  logic [DATA_WIDTH-1:0] b_payload;

  capture_if #(.DATA_WIDTH(DATA_WIDTH)) aw_cap ();
  capture_if #(.DATA_WIDTH(DATA_WIDTH)) w_cap ();
  capture_if #(.DATA_WIDTH(DATA_WIDTH)) b_cap ();

  // payload fields are never stalled, only valid and ready are
  assign m_awaddr  = s_awaddr;
  assign m_awlen   = s_awlen;
  assign m_awsize  = s_awsize;
  assign m_awburst = s_awburst;
  assign m_wdata   = s_wdata;
  assign m_wlast   = s_wlast;
  assign s_bresp   = m_bresp;

  // address sits in the low bits, burst ends up on top
  always_comb begin
    aw_payload = '0;
    aw_payload[AW_BITS-1:0] = {s_awburst, s_awsize, s_awlen, s_awaddr};
  end

  always_comb begin
    b_payload = '0;
    b_payload[sniff_pkg::RESP_WIDTH-1:0] = m_bresp;
  end

  channel_tap #(.DATA_WIDTH(DATA_WIDTH)) u_aw_tap (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (channel_enable[sniff_pkg::CH_AW]),
    .up_valid     (s_awvalid),
    .up_ready     (s_awready),
    .down_valid   (m_awvalid),
    .down_ready   (m_awready),
    .payload      (aw_payload),
    .payload_last (1'b1),
    .cap          (aw_cap)
  );

  channel_tap #(.DATA_WIDTH(DATA_WIDTH)) u_w_tap (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (channel_enable[sniff_pkg::CH_W]),
    .up_valid     (s_wvalid),
    .up_ready     (s_wready),
    .down_valid   (m_wvalid),
    .down_ready   (m_wready),
    .payload      (s_wdata),
    .payload_last (s_wlast),
    .cap          (w_cap)
  );

  // B flows from the manager side back to the subordinate side
  channel_tap #(.DATA_WIDTH(DATA_WIDTH)) u_b_tap (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (channel_enable[sniff_pkg::CH_B]),
    .up_valid     (m_bvalid),
    .up_ready     (m_bready),
    .down_valid   (s_bvalid),
    .down_ready   (s_bready),
    .payload      (b_payload),
    .payload_last (1'b1),
    .cap          (b_cap)
  );

  stream_arbiter #(.DATA_WIDTH(DATA_WIDTH)) u_arbiter (
    .clk           (clk),
    .resetn        (resetn),
    .aw_cap        (aw_cap),
    .w_cap         (w_cap),
    .b_cap         (b_cap),
    .stream_tdata  (stream_tdata),
    .stream_tdest  (stream_tdest),
    .stream_tlast  (stream_tlast),
    .stream_tvalid (stream_tvalid),
    .stream_tready (stream_tready)
  );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

// free running 20 ns clock and a reset held for the first three cycles
module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // resetn is active high, so the design leaves reset when it drops
  initial begin
    resetn = 1'b1;
    repeat (3) @(posedge clk);
    resetn <= 1'b0;
  end

endmodule

//--- testbench/tb_axi_write_sniffer.sv
`timescale 1ns/1ps

module tb_axi_write_sniffer;

  localparam int DATA_WIDTH   = 64;
  localparam int ADDR_WIDTH   = 32;
  localparam int LEN_WIDTH    = 8;
  localparam int N_BURSTS     = 8;
  localparam int STALL_CYCLES = 20;

  logic clk;
  logic resetn;
  logic [2:0] channel_enable;
  logic [ADDR_WIDTH-1:0] s_awaddr, m_awaddr;
  logic [LEN_WIDTH-1:0] s_awlen, m_awlen;
  logic [2:0] s_awsize, m_awsize;
  logic [1:0] s_awburst, m_awburst, s_bresp, m_bresp;
  logic s_awvalid, s_awready, m_awvalid, m_awready;
  logic [DATA_WIDTH-1:0] s_wdata, m_wdata, stream_tdata;
  logic s_wlast, s_wvalid, s_wready, m_wlast, m_wvalid, m_wready;
  logic s_bvalid, s_bready, m_bvalid, m_bready;
  logic stream_tlast, stream_tvalid, stream_tready;
  sniff_pkg::channel_e stream_tdest;

  // expected stream items per channel, last bit on top of the data
  logic [DATA_WIDTH:0] aw_q [$];
  logic [DATA_WIDTH:0] w_q [$];
  logic [DATA_WIDTH:0] b_q [$];
  sniff_pkg::channel_e tag_log [$];
  int aw_hs, w_hs, b_hs, pending_b;
  int errors, checks, test_errors, watchdog_cycles;
  int burst_len [N_BURSTS];
  logic in_w_burst = 1'b0;

  tb_clock_gen u_clock (.clk(clk), .resetn(resetn));

  axi_write_sniffer #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH)
  ) dut (.*);

  // stream word for one AXI handshake, built from the packing rules
  function automatic logic [DATA_WIDTH:0] expected_item(input sniff_pkg::channel_e ch,
      input logic [ADDR_WIDTH-1:0] addr, input logic [LEN_WIDTH-1:0] len,
      input logic [2:0] size, input logic [1:0] burst, input logic [DATA_WIDTH-1:0] data,
      input logic last, input logic [1:0] resp);
    logic [DATA_WIDTH:0] item;
    item = '0;
    case (ch)
      sniff_pkg::CH_AW: begin
        item[ADDR_WIDTH-1:0]                = addr;
        item[ADDR_WIDTH +: LEN_WIDTH]       = len;
        item[ADDR_WIDTH + LEN_WIDTH +: 3]   = size;
        item[ADDR_WIDTH + LEN_WIDTH + 3 +: 2] = burst;
        item[DATA_WIDTH]                    = 1'b1;
      end
      sniff_pkg::CH_W: item = {last, data};
      default: begin
        item[1:0]        = resp;
        item[DATA_WIDTH] = 1'b1;
      end
    endcase
    return item;
  endfunction

  function automatic int count_tag(input sniff_pkg::channel_e ch);
    int n;
    n = 0;
    foreach (tag_log[i]) begin
      if (tag_log[i] == ch) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic require(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Error at %0d ns: %s", $time, what);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  task automatic send_aw(input logic [ADDR_WIDTH-1:0] addr, input int len);
    @(posedge clk);
    s_awaddr  <= addr;
    s_awlen   <= LEN_WIDTH'(len);
    s_awsize  <= 3'($urandom);
    s_awburst <= 2'($urandom);
    s_awvalid <= 1'b1;
    do @(posedge clk); while (!s_awready);
    s_awvalid <= 1'b0;
  endtask

  task automatic send_w(input int beats);
    @(posedge clk);
    for (int b = 0; b < beats; b++) begin
      s_wdata  <= {$urandom, $urandom};
      s_wlast  <= (b == beats - 1);
      s_wvalid <= 1'b1;
      do @(posedge clk); while (!s_wready);
    end
    s_wvalid <= 1'b0;
    s_wlast  <= 1'b0;
  endtask

  task automatic do_write(input int beats);
    int b_target;
    b_target = b_hs + 1;
    fork
      send_aw($urandom, beats - 1);
      send_w(beats);
    join
    wait (b_hs >= b_target);
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((aw_q.size() + w_q.size() + b_q.size() != 0 || stream_tvalid) && cycles < 400) begin
      @(posedge clk);
      cycles++;
    end
    require(aw_q.size() + w_q.size() + b_q.size() == 0, "captured items never left on the stream");
  endtask

  // stub manager that takes every address and data beat and answers each burst once
  always @(posedge clk) begin
    if (resetn) begin
      m_awready <= 1'b0;
      m_wready  <= 1'b0;
      m_bvalid  <= 1'b0;
      pending_b = 0;
    end else begin
      m_awready <= ($urandom % 4) != 0;
      m_wready  <= ($urandom % 4) != 0;
      if (m_wvalid && m_wready && m_wlast) begin
        pending_b++;
      end
      if (!m_bvalid || m_bready) begin
        m_bvalid <= pending_b > 0;
        m_bresp  <= 2'($urandom);
        if (pending_b > 0) begin
          pending_b--;
        end
      end
    end
  end

  // every handshake seen at the subordinate ports becomes one expectation
  // and the other side of the DUT has to show the same transfer
  always @(posedge clk) begin
    if (!resetn) begin
      if (s_awvalid && s_awready) begin
        aw_hs++;
        checks++;
        assert (m_awvalid && m_awaddr == s_awaddr && m_awlen == s_awlen &&
                m_awsize == s_awsize && m_awburst == s_awburst) else begin
          errors++;
          $display("Error at %0d ns: AW handshake did not reach the manager side intact",
                   $time);
        end
        if (channel_enable[sniff_pkg::CH_AW]) begin
          aw_q.push_back(expected_item(sniff_pkg::CH_AW, s_awaddr, s_awlen, s_awsize,
                                       s_awburst, '0, 1'b1, '0));
        end
      end
      if (s_wvalid && s_wready) begin
        w_hs++;
        checks++;
        assert (m_wvalid && m_wdata == s_wdata && m_wlast == s_wlast) else begin
          errors++;
          $display("Error at %0d ns: W handshake did not reach the manager side intact",
                   $time);
        end
        if (channel_enable[sniff_pkg::CH_W]) begin
          w_q.push_back(expected_item(sniff_pkg::CH_W, '0, '0, '0, '0, s_wdata, s_wlast, '0));
        end
      end
      if (s_bvalid && s_bready) begin
        b_hs++;
        checks++;
        assert (m_bready && s_bresp == m_bresp) else begin
          errors++;
          $display("Error at %0d ns: B handshake did not reach the subordinate side intact",
                   $time);
        end
        if (channel_enable[sniff_pkg::CH_B]) begin
          b_q.push_back(expected_item(sniff_pkg::CH_B, '0, '0, '0, '0, '0, 1'b1, m_bresp));
        end
      end
    end
  end

  always @(posedge clk) begin : compare
    logic [DATA_WIDTH:0] got;
    logic [DATA_WIDTH:0] want;
    bit found;
    if (!resetn && stream_tvalid && stream_tready) begin
      got   = {stream_tlast, stream_tdata};
      found = 1'b0;
      tag_log.push_back(stream_tdest);
      assert (!in_w_burst || stream_tdest == sniff_pkg::CH_W) else begin
        errors++;
        $display("Error at %0d ns: %s item cut into a W burst", $time, stream_tdest.name());
      end
      if (stream_tdest == sniff_pkg::CH_W) begin
        in_w_burst = !stream_tlast;
      end
      case (stream_tdest)
        sniff_pkg::CH_AW: found = aw_q.size() > 0;
        sniff_pkg::CH_W: found = w_q.size() > 0;
        default: found = b_q.size() > 0;
      endcase
      assert (found) else begin
        errors++;
        $display("stream item tagged %s at %0d ns has no AXI handshake behind it",
                 stream_tdest.name(), $time);
      end
      if (found) begin
        case (stream_tdest)
          sniff_pkg::CH_AW: want = aw_q.pop_front();
          sniff_pkg::CH_W: want = w_q.pop_front();
          default: want = b_q.pop_front();
        endcase
        checks++;
        assert (got == want) else begin
          errors++;
          $display("Error at %0d ns: %s item data %h last %b, expected data %h last %b",
                   $time, stream_tdest.name(), got[DATA_WIDTH-1:0], got[DATA_WIDTH],
                   want[DATA_WIDTH-1:0], want[DATA_WIDTH]);
        end
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : run_tests
    int total_beats;
    int w_start;
    int aw_start;
    int b_start;
    void'($urandom(99805));
    channel_enable = 3'b111;
    s_awaddr       = '0;
    s_awlen        = '0;
    s_awsize       = 3'd3;
    s_awburst      = 2'b01;
    s_awvalid      = 1'b0;
    s_wdata        = '0;
    s_wlast        = 1'b0;
    s_wvalid       = 1'b0;
    s_bready       = 1'b1;
    m_awready      = 1'b0;
    m_wready       = 1'b0;
    m_bresp        = '0;
    m_bvalid       = 1'b0;
    stream_tready  = 1'b0;
    // AW and B count as one beat each next to the W beats of every write
    total_beats = 3 + 3 + 7 + 8;
    for (int i = 0; i < N_BURSTS; i++) begin
      burst_len[i] = 1 + ($urandom % 8);
      total_beats += burst_len[i] + 2;
    end
    watchdog_cycles = total_beats * 40;
    wait (resetn === 1'b0);
    @(posedge clk);
    stream_tready <= 1'b1;

    do_write(1);
    wait_drained();
    require(count_tag(sniff_pkg::CH_AW) == 1 && count_tag(sniff_pkg::CH_W) == 1 &&
            count_tag(sniff_pkg::CH_B) == 1, "single write did not give one item per channel");
    end_test("single write");

    // addresses and data run ahead of each other, so AW items compete with W bursts
    b_start = b_hs;
    fork
      begin
        fork
          for (int i = 0; i < N_BURSTS; i++) send_aw($urandom, burst_len[i] - 1);
          for (int i = 0; i < N_BURSTS; i++) send_w(burst_len[i]);
        join
        wait (b_hs >= b_start + N_BURSTS);
      end
      while (b_hs < b_start + N_BURSTS) begin
        @(posedge clk);
        stream_tready <= ($urandom % 4) != 0;
      end
    join
    stream_tready <= 1'b1;
    wait_drained();
    end_test("bursts");

    tag_log.delete();
    stream_tready <= 1'b0;
    b_start = b_hs;
    send_aw($urandom, 0);
    send_w(1);
    wait (b_hs > b_start);
    @(posedge clk);
    require(stream_tvalid, "stream_tvalid stayed low with all three slots full");
    stream_tready <= 1'b1;
    wait_drained();
    require(tag_log.size() == 3 && tag_log[0] == sniff_pkg::CH_AW &&
            tag_log[1] == sniff_pkg::CH_W && tag_log[2] == sniff_pkg::CH_B,
            "round robin order was not AW, W, B");
    end_test("round robin");

    stream_tready <= 1'b0;
    aw_start = aw_hs;
    w_start  = w_hs;
    b_start  = b_hs;
    // a second address waits behind the first one while the stream is stalled
    fork
      begin
        fork
          begin
            send_aw($urandom, 3);
            send_aw($urandom, 0);
          end
          send_w(4);
        join
        wait (b_hs > b_start);
      end
      begin
        repeat (STALL_CYCLES) @(posedge clk);
        require(w_hs - w_start <= 1 && !s_wready, "W kept accepting beats during the stall");
        require(aw_hs - aw_start <= 1 && !s_awready && b_hs == b_start,
                "AW or B moved too far in the stall");
        stream_tready <= 1'b1;
      end
    join
    wait_drained();
    end_test("back-pressure");

    tag_log.delete();
    channel_enable <= 3'b101;
    do_write(2);
    do_write(2);
    wait_drained();
    require(count_tag(sniff_pkg::CH_W) == 0 && count_tag(sniff_pkg::CH_AW) == 2 &&
            count_tag(sniff_pkg::CH_B) == 2, "capture enable did not mask the W channel");
    channel_enable <= 3'b111;
    end_test("capture enable");

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
source/sniff_pkg.sv
source/capture_if.sv
source/channel_tap.sv
source/stream_arbiter.sv
source/axi_write_sniffer.sv
testbench/tb_clock_gen.sv
testbench/tb_axi_write_sniffer.sv

//--- Bender.yml
package:
  name: axi_write_sniffer

sources:
  - source/sniff_pkg.sv
  - source/capture_if.sv
  - source/channel_tap.sv
  - source/stream_arbiter.sv
  - source/axi_write_sniffer.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_axi_write_sniffer.sv
